// File: build_sim.sh
#!/bin/sh
# Build with Verilator, run, then judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module motor_ctrl_tb \
    -f motor_ctrl_top.f -o motor_ctrl_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/motor_ctrl_sim > sim.log 2>&1 || echo "simulator exited with a nonzero status"
cat sim.log
grep -q "Checks failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "All checks passed" sim.log || { echo "FAIL, no result line in sim.log"; exit 1; }
echo "PASS"

// File: motor_ctrl_top.f
src/board_pkg.sv
src/host_link.sv
src/block_writer.sv
src/channel_regs.sv
src/data_sampler.sv
src/motor_ctrl_top.sv
sim/tb_clock.sv
sim/motor_ctrl_properties.sv
sim/motor_ctrl_tb.sv

// File: sim/motor_ctrl_properties.sv
`default_nettype none

module motor_ctrl_properties (
    input logic sysclk,
    input logic reset,
    input logic cmd_req,
    input logic cmd_ack,
    input logic host_wen,
    input logic bw_active
);

    // Ack raised only on an edge where the request was seen high
    ack_needs_req: assert property (@(posedge sysclk) disable iff (reset)
        $rose(cmd_ack) |-> $past(cmd_req))
        else $error("cmd_ack rose without a pending cmd_req");

    // Back-pressure, ack held as long as the host holds req
    ack_held: assert property (@(posedge sysclk) disable iff (reset)
        cmd_ack && cmd_req |=> cmd_ack)
        else $error("cmd_ack fell while cmd_req was still high");

    // Host strobe silent while the block writer owns the bus
    bus_owner: assert property (@(posedge sysclk) disable iff (reset)
        bw_active |-> !host_wen)
        else $error("host write strobe seen while the block writer owned the bus");

endmodule

bind motor_ctrl_top motor_ctrl_properties u_motor_ctrl_properties (
    .sysclk    (sysclk),
    .reset     (reset),
    .cmd_req   (cmd_req),
    .cmd_ack   (cmd_ack),
    .host_wen  (u_host_link.host_wen),
    .bw_active (bw_active)
);

`default_nettype wire

// File: sim/motor_ctrl_tb.sv
`default_nettype none

module motor_ctrl_tb;

    typedef struct packed {
        logic                           wr;         // 1 write, 0 read
        logic [board_pkg::ADDR_W-1:0]   addr;
        logic [board_pkg::DATA_W-1:0]   wdata;
        logic [board_pkg::DATA_W-1:0]   expected;
        logic                           check_ts;   // Compare against previous timestamp
    } cmd_entry_t;

    logic                           sysclk;
    logic                           reset;
    logic                           cmd_req;
    logic                           cmd_write;
    logic [board_pkg::ADDR_W-1:0]   cmd_addr;
    logic [board_pkg::DATA_W-1:0]   cmd_wdata;
    logic                           cmd_ack;
    logic [board_pkg::DATA_W-1:0]   cmd_rdata;
    logic [3:0]                     board_id;

    // Reference model of the board state
    logic [board_pkg::SETPT_W-1:0]  adc_model   [board_pkg::NUM_CHAN];
    logic [board_pkg::SETPT_W-1:0]  setpt_model [board_pkg::NUM_CHAN];
    logic [board_pkg::DATA_W-1:0]   snap_model  [board_pkg::SAMPLE_WORDS];

    cmd_entry_t                     tests [$];
    logic [board_pkg::DATA_W-1:0]   last_ts;
    logic [board_pkg::DATA_W-1:0]   got;
    int                             errors;
    int                             cycles;
    int                             cycle_limit;

    tb_clock u_tb_clock (.sysclk(sysclk));

    motor_ctrl_top u_motor_ctrl_top (
        .sysclk      (sysclk),
        .reset       (reset),
        .cmd_req     (cmd_req),
        .cmd_write   (cmd_write),
        .cmd_addr    (cmd_addr),
        .cmd_wdata   (cmd_wdata),
        .cmd_ack     (cmd_ack),
        .cmd_rdata   (cmd_rdata),
        .board_id    (board_id),
        .adc_value_0 (adc_model[0]),
        .adc_value_1 (adc_model[1]),
        .adc_value_2 (adc_model[2]),
        .adc_value_3 (adc_model[3])
    );

    function automatic logic [15:0] chan_addr(input int chan, input int offset);
        return 16'(int'(board_pkg::CHAN_BASE) + 16 * chan + offset);
    endfunction

    // Read value from the register map rules
    function automatic logic [31:0] expected_read(input logic [15:0] addr);
        int          a;
        int          off;
        logic [31:0] val;
        a   = int'(addr);
        off = a - int'(board_pkg::CHAN_BASE);
        val = '0;
        if (addr == board_pkg::ADDR_STATUS) begin
            val[15:8] = board_pkg::STATUS_TAG;
            val[3:0]  = board_id;
        end else if (off >= 0 && off < 16 * board_pkg::NUM_CHAN) begin
            if (off % 16 == 0) val[15:0] = setpt_model[off / 16];
            else if (off % 16 == 1) val[15:0] = adc_model[off / 16];   // Feedback
        end else if (a > int'(board_pkg::SAMPLE_BASE) &&
                     a < int'(board_pkg::SAMPLE_BASE) + board_pkg::SAMPLE_WORDS) begin
            val = snap_model[a - int'(board_pkg::SAMPLE_BASE)];
        end
        return val;
    endfunction

    task automatic add_write(input logic [15:0] addr, input logic [31:0] data);
        cmd_entry_t e;
        int         off;
        off = int'(addr) - int'(board_pkg::CHAN_BASE);
        if (off >= 0 && off < 16 * board_pkg::NUM_CHAN && off % 16 == 0) begin
            setpt_model[off / 16] = data[15:0];
        end else if (addr == board_pkg::ADDR_BLOCK) begin
            for (int c = 0; c < board_pkg::NUM_CHAN; c++) begin
                if (data[16 + c]) setpt_model[c] = data[15:0];     // Mask in 19:16
            end
        end
        e = '{wr: 1'b1, addr: addr, wdata: data, expected: '0, check_ts: 1'b0};
        tests.push_back(e);
    endtask

    task automatic add_read(input logic [15:0] addr, input logic check_ts);
        cmd_entry_t e;
        if (addr == board_pkg::SAMPLE_BASE) begin
            for (int c = 0; c < board_pkg::NUM_CHAN; c++) begin
                snap_model[c + 1] = {setpt_model[c], adc_model[c]};
            end
        end
        e = '{wr: 1'b0, addr: addr, wdata: '0, expected: expected_read(addr), check_ts: check_ts};
        tests.push_back(e);
    endtask

    task automatic fill_table();
        add_read(board_pkg::ADDR_STATUS, 1'b0);
        add_write(chan_addr(0, 0), 32'hdead_1234);   // Upper bits dropped
        add_write(chan_addr(1, 0), 32'h0000_0a5a);
        add_write(chan_addr(2, 0), 32'hffff_8001);
        add_write(chan_addr(3, 0), 32'h0001_7ffe);
        for (int c = 0; c < board_pkg::NUM_CHAN; c++) add_read(chan_addr(c, 0), 1'b0);
        for (int c = 0; c < board_pkg::NUM_CHAN; c++) add_read(chan_addr(c, 1), 1'b0);
        add_write(chan_addr(0, 1), 32'h0000_ffff);   // Feedback is read-only
        add_write(chan_addr(1, 1), 32'h1234_5678);
        add_write(board_pkg::ADDR_STATUS, 32'hffff_ffff);
        add_read(chan_addr(0, 1), 1'b0);
        add_read(chan_addr(1, 1), 1'b0);
        add_read(chan_addr(0, 0), 1'b0);
        add_read(board_pkg::ADDR_STATUS, 1'b0);
        add_write(board_pkg::ADDR_BLOCK, {12'h000, 4'b0101, 16'h3c3c});   // Channels 0 and 2
        for (int c = 0; c < board_pkg::NUM_CHAN; c++) add_read(chan_addr(c, 0), 1'b0);
        add_write(board_pkg::ADDR_BLOCK, {12'h000, 4'b1000, 16'hc001});
        for (int c = 0; c < board_pkg::NUM_CHAN; c++) add_read(chan_addr(c, 0), 1'b0);
        add_read(board_pkg::ADDR_TIMESTAMP, 1'b1);
        add_read(board_pkg::ADDR_TIMESTAMP, 1'b1);
        add_read(board_pkg::SAMPLE_BASE, 1'b1);
        for (int k = 1; k < board_pkg::SAMPLE_WORDS; k++) begin
            add_read(board_pkg::SAMPLE_BASE + 16'(k), 1'b0);
        end
        add_write(chan_addr(1, 0), 32'h0000_beef);   // Change state between snapshots
        add_read(board_pkg::SAMPLE_BASE, 1'b1);
        for (int k = 1; k < board_pkg::SAMPLE_WORDS; k++) begin
            add_read(board_pkg::SAMPLE_BASE + 16'(k), 1'b0);
        end
        add_read(16'h0005, 1'b0);                    // Unmapped space
        add_read(chan_addr(2, 2), 1'b0);
        add_read(chan_addr(4, 0), 1'b0);
        add_read(board_pkg::ADDR_BLOCK, 1'b0);
        add_read(board_pkg::SAMPLE_BASE + 16'(board_pkg::SAMPLE_WORDS), 1'b0);
        add_read(16'h0300, 1'b0);
    endtask

    // Full four-phase exchange, req held one extra cycle after ack
    task automatic run_command(input cmd_entry_t t, output logic [31:0] rdata);
        @(posedge sysclk);
        #2;
        cmd_write = t.wr;
        cmd_addr  = t.addr;
        cmd_wdata = t.wdata;
        cmd_req   = 1'b1;
        while (!cmd_ack) begin
            @(posedge sysclk);
            #2;
        end
        rdata = cmd_rdata;
        @(posedge sysclk);
        #2;
        assert (cmd_ack) else begin
            errors++;
            $display("cmd_ack dropped while cmd_req was still held high");
        end
        cmd_req = 1'b0;
        while (cmd_ack) begin
            @(posedge sysclk);
            #2;
        end
    endtask

    task automatic check_read(input cmd_entry_t t, input logic [31:0] rdata);
        if (t.check_ts) begin
            assert (rdata > last_ts) else begin
                errors++;
                $display("error: cmd_rdata timestamp at addr %h is %h, previous %h",
                         t.addr, rdata, last_ts);
            end
            last_ts = rdata;
        end else begin
            assert (rdata == t.expected) else begin
                errors++;
                $display("error: cmd_rdata at addr %h is %h, expected %h",
                         t.addr, rdata, t.expected);
            end
        end
    endtask

    // Run limit from the table length
    always @(posedge sysclk) begin
        cycles = cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("timeout: host handshake did not finish within %0d cycles", cycle_limit);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        reset       = 1'b1;
        cmd_req     = 1'b0;
        cmd_write   = 1'b0;
        cmd_addr    = '0;
        cmd_wdata   = '0;
        board_id    = 4'ha;
        errors      = 0;
        cycles      = 0;
        cycle_limit = 0;
        last_ts     = '0;
        void'($urandom(32'h805a));          // Single seeding
        for (int c = 0; c < board_pkg::NUM_CHAN; c++) begin
            adc_model[c]   = 16'($urandom());
            setpt_model[c] = '0;            // Reset value
        end
        for (int k = 0; k < board_pkg::SAMPLE_WORDS; k++) snap_model[k] = '0;
        fill_table();
        cycle_limit = tests.size() * 20 + 50;
        repeat (5) @(posedge sysclk);
        #2;
        reset = 1'b0;
        for (int i = 0; i < tests.size(); i++) begin
            run_command(tests[i], got);
            if (!tests[i].wr) check_read(tests[i], got);
        end
        $display("%0d commands run, %0d errors", tests.size(), errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/tb_clock.sv
`default_nettype none

module tb_clock (
    output logic sysclk
);

    initial sysclk = 1'b0;
    always #20 sysclk = ~sysclk;    // 40 unit period

endmodule

`default_nettype wire

// File: src/block_writer.sv
`default_nettype none

module block_writer (
    input  logic                                sysclk,
    input  logic                                reset,
    input  logic                                bw_start,
    input  logic [board_pkg::DATA_W-1:0]        bw_data,
    output logic                                bw_active,
    output logic [board_pkg::ADDR_W-1:0]        bw_addr,
    output logic [board_pkg::DATA_W-1:0]        bw_wdata,
    output logic                                bw_wen
);

    logic [board_pkg::SETPT_W-1:0]      setpt_q;    // Value for every selected channel
    logic [board_pkg::NUM_CHAN-1:0]     mask_q;
    logic [board_pkg::CHAN_IDX_W-1:0]   chan_cnt;   // Channel being visited
    logic [board_pkg::ADDR_W-1:0]       chan_off;

    // Start cycle latches, then one cycle per channel
    always_ff @(posedge sysclk) begin
        if (reset) begin
            bw_active <= 1'b0;
            chan_cnt  <= '0;
        end else if (bw_active) begin
            chan_cnt <= chan_cnt + 1'b1;
            if (chan_cnt == board_pkg::CHAN_LAST) bw_active <= 1'b0;    // Last channel done
        end else if (bw_start) begin
            bw_active <= 1'b1;
            chan_cnt  <= '0;
        end
    end

    always_ff @(posedge sysclk) begin
        if (bw_start && !bw_active) begin
            setpt_q <= bw_data[board_pkg::SETPT_W-1:0];
            mask_q  <= bw_data[board_pkg::SETPT_W +: board_pkg::NUM_CHAN];
        end
    end

    // Channel stride as an address offset
    always_comb begin
        chan_off = '0;
        chan_off[board_pkg::CHAN_SHIFT +: board_pkg::CHAN_IDX_W] = chan_cnt;
    end

    assign bw_addr  = board_pkg::CHAN_BASE + chan_off;  // Setpoint is offset 0
    assign bw_wdata = {{(board_pkg::DATA_W-board_pkg::SETPT_W){1'b0}}, setpt_q};
    assign bw_wen   = bw_active && mask_q[chan_cnt];    // Masked-off channels skipped

endmodule

`default_nettype wire

// File: src/board_pkg.sv
`default_nettype none

package board_pkg;

    // Bus and channel geometry
    localparam int NUM_CHAN   = 4;
    localparam int ADDR_W     = 16;
    localparam int DATA_W     = 32;
    localparam int SETPT_W    = 16;                  // Setpoint and ADC sample width
    localparam int CHAN_IDX_W = $clog2(NUM_CHAN);
    localparam int CHAN_SHIFT = 4;                   // 16 register slots per channel

    localparam logic [CHAN_IDX_W-1:0] CHAN_LAST = CHAN_IDX_W'(NUM_CHAN - 1);

    // Status word tag, sits above the board id
    localparam logic [7:0] STATUS_TAG = 8'h51;

    // Global registers
    localparam logic [ADDR_W-1:0] ADDR_STATUS    = 16'h0000;
    localparam logic [ADDR_W-1:0] ADDR_TIMESTAMP = 16'h0001;

    // Channel space, setpoint at offset 0 and feedback at offset 1
    localparam logic [ADDR_W-1:0] CHAN_BASE  = 16'h0010;
    localparam logic [ADDR_W-1:0] CHAN_LIMIT = CHAN_BASE + ADDR_W'(NUM_CHAN << CHAN_SHIFT);

    // Real-time block write, mask in bits 19:16
    localparam logic [ADDR_W-1:0] ADDR_BLOCK = 16'h0100;

    // Sample buffer, timestamp then one word per channel
    localparam int SAMPLE_WORDS = NUM_CHAN + 1;
    localparam int SAMPLE_AW    = $clog2(SAMPLE_WORDS);

    localparam logic [ADDR_W-1:0] SAMPLE_BASE  = 16'h0200;
    localparam logic [ADDR_W-1:0] SAMPLE_LIMIT = SAMPLE_BASE + ADDR_W'(SAMPLE_WORDS);

    localparam logic [SAMPLE_AW-1:0] SAMPLE_LAST = SAMPLE_AW'(SAMPLE_WORDS - 1);

endpackage

`default_nettype wire

// File: src/channel_regs.sv
`default_nettype none

module channel_regs (
    input  logic                                                sysclk,
    input  logic                                                reset,
    input  logic [board_pkg::ADDR_W-1:0]                        reg_addr,
    input  logic [board_pkg::DATA_W-1:0]                        reg_wdata,
    input  logic                                                reg_wen,
    output logic [board_pkg::DATA_W-1:0]                        chan_rdata,
    // ADC feedback per channel
    input  logic [board_pkg::SETPT_W-1:0]                       adc_value_0,
    input  logic [board_pkg::SETPT_W-1:0]                       adc_value_1,
    input  logic [board_pkg::SETPT_W-1:0]                       adc_value_2,
    input  logic [board_pkg::SETPT_W-1:0]                       adc_value_3,
    // Flat views for the sampler
    output logic [board_pkg::NUM_CHAN*board_pkg::SETPT_W-1:0]   setpt_all,
    output logic [board_pkg::NUM_CHAN*board_pkg::SETPT_W-1:0]   adc_all
);

    logic [board_pkg::SETPT_W-1:0]      setpt [board_pkg::NUM_CHAN];
    logic [board_pkg::SETPT_W-1:0]      adc   [board_pkg::NUM_CHAN];
    logic [board_pkg::ADDR_W-1:0]       chan_off;   // Address relative to channel 0
    logic [board_pkg::CHAN_IDX_W-1:0]   chan_idx;
    logic [board_pkg::CHAN_SHIFT-1:0]   reg_off;    // Register inside the channel

    assign adc[0] = adc_value_0;
    assign adc[1] = adc_value_1;
    assign adc[2] = adc_value_2;
    assign adc[3] = adc_value_3;

    // Channel and offset split
    assign chan_off = reg_addr - board_pkg::CHAN_BASE;
    assign chan_idx = chan_off[board_pkg::CHAN_SHIFT +: board_pkg::CHAN_IDX_W];
    assign reg_off  = chan_off[board_pkg::CHAN_SHIFT-1:0];

    // Only offset 0 is writable
    always_ff @(posedge sysclk) begin
        if (reset) begin
            for (int i = 0; i < board_pkg::NUM_CHAN; i++) begin
                setpt[i] <= '0;
            end
        end else if (reg_wen && reg_off == '0) begin
            setpt[chan_idx] <= reg_wdata[board_pkg::SETPT_W-1:0];
        end
    end

    // Read back, zero extended
    always_comb begin
        chan_rdata = '0;
        if (reg_off == '0) begin
            chan_rdata[board_pkg::SETPT_W-1:0] = setpt[chan_idx];
        end else if (reg_off == 1) begin
            chan_rdata[board_pkg::SETPT_W-1:0] = adc[chan_idx];    // Feedback
        end
    end

    for (genvar i = 0; i < board_pkg::NUM_CHAN; i++) begin : g_flat
        assign setpt_all[i*board_pkg::SETPT_W +: board_pkg::SETPT_W] = setpt[i];
        assign adc_all[i*board_pkg::SETPT_W +: board_pkg::SETPT_W]   = adc[i];
    end

endmodule

`default_nettype wire

// File: src/data_sampler.sv
`default_nettype none

module data_sampler (
    input  logic                                                sysclk,
    input  logic                                                reset,
    input  logic                                                sample_start,
    output logic                                                sample_busy,
    input  logic [board_pkg::SAMPLE_AW-1:0]                     sample_raddr,
    output logic [board_pkg::DATA_W-1:0]                        sample_rdata,
    input  logic [board_pkg::NUM_CHAN*board_pkg::SETPT_W-1:0]   setpt_all,
    input  logic [board_pkg::NUM_CHAN*board_pkg::SETPT_W-1:0]   adc_all,
    output logic [board_pkg::DATA_W-1:0]                        timestamp
);

    logic [board_pkg::DATA_W-1:0]       sample_buf [board_pkg::SAMPLE_WORDS];
    logic [board_pkg::SAMPLE_AW-1:0]    widx;       // Word being captured
    logic [board_pkg::CHAN_IDX_W-1:0]   chan_sel;   // Channel for words 1 and up
    logic [board_pkg::DATA_W-1:0]       cap_word;

    // Free-running cycle count, busy for one cycle per word
    always_ff @(posedge sysclk) begin
        if (reset) begin
            timestamp   <= '0;
            sample_busy <= 1'b0;
            widx        <= '0;
        end else begin
            timestamp <= timestamp + 1'b1;
            if (sample_busy) begin
                widx <= widx + 1'b1;
                if (widx == board_pkg::SAMPLE_LAST) sample_busy <= 1'b0;
            end else if (sample_start) begin
                sample_busy <= 1'b1;
                widx        <= '0;
            end
        end
    end

    assign chan_sel = widx[board_pkg::CHAN_IDX_W-1:0] - 1'b1;   // Word 1 is channel 0

    // Setpoint high half, feedback low half
    always_comb begin
        if (widx == '0) begin
            cap_word = timestamp;
        end else begin
            cap_word = {setpt_all[chan_sel*board_pkg::SETPT_W +: board_pkg::SETPT_W],
                        adc_all[chan_sel*board_pkg::SETPT_W +: board_pkg::SETPT_W]};
        end
    end

    always_ff @(posedge sysclk) begin
        if (sample_busy) sample_buf[widx] <= cap_word;
    end

    assign sample_rdata = sample_buf[sample_raddr];     // Async read by index

endmodule

`default_nettype wire

// File: src/host_link.sv
`default_nettype none

module host_link (
    input  logic                                sysclk,
    input  logic                                reset,
    // Host command port, four-phase
    input  logic                                cmd_req,
    input  logic                                cmd_write,
    input  logic [board_pkg::ADDR_W-1:0]        cmd_addr,
    input  logic [board_pkg::DATA_W-1:0]        cmd_wdata,
    output logic                                cmd_ack,
    output logic [board_pkg::DATA_W-1:0]        cmd_rdata,
    input  logic [3:0]                          board_id,
    // Register bus into the channel block
    output logic [board_pkg::ADDR_W-1:0]        reg_addr,
    output logic [board_pkg::DATA_W-1:0]        reg_wdata,
    output logic                                reg_wen,
    input  logic [board_pkg::DATA_W-1:0]        chan_rdata,
    // Block writer
    output logic                                bw_start,
    output logic [board_pkg::DATA_W-1:0]        bw_data,
    input  logic                                bw_active,
    input  logic [board_pkg::ADDR_W-1:0]        bw_addr,
    input  logic [board_pkg::DATA_W-1:0]        bw_wdata,
    input  logic                                bw_wen,
    // Data sampler
    output logic                                sample_start,
    output logic [board_pkg::SAMPLE_AW-1:0]     sample_raddr,
    input  logic                                sample_busy,
    input  logic [board_pkg::DATA_W-1:0]        sample_rdata,
    input  logic [board_pkg::DATA_W-1:0]        timestamp
);

    typedef enum logic [2:0] {
        ST_IDLE,                                // Waiting for cmd_req
        ST_EXEC,                                // Perform captured command
        ST_WAIT_BW,                             // Block writer owns the bus
        ST_WAIT_SMP,                            // Sampler filling its buffer
        ST_ACK                                  // Holding ack until req drops
    } state_t;

    state_t                         state;
    logic                           wr_q;       // Captured command
    logic [board_pkg::ADDR_W-1:0]   addr_q;
    logic [board_pkg::DATA_W-1:0]   wdata_q;
    logic [board_pkg::ADDR_W-1:0]   smp_off;    // Offset into sample space
    logic                           is_status, is_tstamp, is_chan, is_block, is_sample;
    logic                           host_wen;   // Host's own write strobe, excludes block writes
    logic [board_pkg::DATA_W-1:0]   rd_mux;

    // Address decode, only done here
    assign is_status = addr_q == board_pkg::ADDR_STATUS;
    assign is_tstamp = addr_q == board_pkg::ADDR_TIMESTAMP;
    assign is_chan   = addr_q >= board_pkg::CHAN_BASE && addr_q < board_pkg::CHAN_LIMIT;
    assign is_block  = addr_q == board_pkg::ADDR_BLOCK;
    assign is_sample = addr_q >= board_pkg::SAMPLE_BASE && addr_q < board_pkg::SAMPLE_LIMIT;
    assign smp_off   = addr_q - board_pkg::SAMPLE_BASE;

    // Strobes, one cycle in the execute state
    assign host_wen     = state == ST_EXEC && wr_q && is_chan;
    assign bw_start     = state == ST_EXEC && wr_q && is_block;
    assign sample_start = state == ST_EXEC && !wr_q && is_sample && smp_off == '0;

    // Bus mux, block writer takes over while active
    assign reg_addr  = bw_active ? bw_addr  : addr_q;
    assign reg_wdata = bw_active ? bw_wdata : wdata_q;
    assign reg_wen   = bw_active ? bw_wen   : host_wen;
    assign bw_data   = wdata_q;                 // Mask and setpoint pass straight through

    assign sample_raddr = smp_off[board_pkg::SAMPLE_AW-1:0];    // Word 0 while sampling

    // Read data select, unmapped reads give zero
    always_comb begin
        rd_mux = '0;
        if (is_status) begin
            rd_mux = {{(board_pkg::DATA_W-16){1'b0}}, board_pkg::STATUS_TAG, 4'h0, board_id};
        end else if (is_tstamp) begin
            rd_mux = timestamp;
        end else if (is_chan) begin
            rd_mux = chan_rdata;
        end else if (is_sample) begin
            rd_mux = sample_rdata;
        end
    end

    // Handshake FSM
    always_ff @(posedge sysclk) begin
        if (reset) begin
            state   <= ST_IDLE;
            cmd_ack <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cmd_req) state <= ST_EXEC;
                end
                ST_EXEC: begin
                    if (wr_q && is_block) begin
                        state <= ST_WAIT_BW;
                    end else if (sample_start) begin
                        state <= ST_WAIT_SMP;
                    end else begin
                        state   <= ST_ACK;
                        cmd_ack <= 1'b1;
                    end
                end
                ST_WAIT_BW, ST_WAIT_SMP: begin
                    if (!(bw_active || sample_busy)) begin  // Busy dropped last cycle
                        state   <= ST_ACK;
                        cmd_ack <= 1'b1;
                    end
                end
                default: begin
                    if (!cmd_req) begin
                        state   <= ST_IDLE;
                        cmd_ack <= 1'b0;
                    end
                end
            endcase
        end
    end

    // Command capture and read data
    always_ff @(posedge sysclk) begin
        if (state == ST_IDLE && cmd_req) begin
            wr_q    <= cmd_write;
            addr_q  <= cmd_addr;
            wdata_q <= cmd_wdata;
        end
        if (state == ST_EXEC) cmd_rdata <= rd_mux;
        if (state == ST_WAIT_SMP && !sample_busy) cmd_rdata <= sample_rdata;   // Fresh timestamp
    end

endmodule

`default_nettype wire

// File: src/motor_ctrl_top.sv
`default_nettype none

module motor_ctrl_top (
    input  logic                            sysclk,
    input  logic                            reset,
    // Host command port
    input  logic                            cmd_req,
    input  logic                            cmd_write,
    input  logic [board_pkg::ADDR_W-1:0]    cmd_addr,
    input  logic [board_pkg::DATA_W-1:0]    cmd_wdata,
    output logic                            cmd_ack,
    output logic [board_pkg::DATA_W-1:0]    cmd_rdata,
    // Board inputs
    input  logic [3:0]                      board_id,
    input  logic [board_pkg::SETPT_W-1:0]   adc_value_0,
    input  logic [board_pkg::SETPT_W-1:0]   adc_value_1,
    input  logic [board_pkg::SETPT_W-1:0]   adc_value_2,
    input  logic [board_pkg::SETPT_W-1:0]   adc_value_3
);

    // Register bus
    logic [board_pkg::ADDR_W-1:0]   reg_addr;
    logic [board_pkg::DATA_W-1:0]   reg_wdata;
    logic                           reg_wen;
    logic [board_pkg::DATA_W-1:0]   chan_rdata;

    // Block write path
    logic                           bw_start;
    logic [board_pkg::DATA_W-1:0]   bw_data;
    logic                           bw_active;      // Block writer drives the bus
    logic [board_pkg::ADDR_W-1:0]   bw_addr;
    logic [board_pkg::DATA_W-1:0]   bw_wdata;
    logic                           bw_wen;

    // Sampling path
    logic                                                   sample_start;
    logic                                                   sample_busy;
    logic [board_pkg::SAMPLE_AW-1:0]                        sample_raddr;
    logic [board_pkg::DATA_W-1:0]                           sample_rdata;
    logic [board_pkg::DATA_W-1:0]                           timestamp;
    logic [board_pkg::NUM_CHAN*board_pkg::SETPT_W-1:0]      setpt_all;
    logic [board_pkg::NUM_CHAN*board_pkg::SETPT_W-1:0]      adc_all;

    // Host side, owns the bus
    host_link u_host_link (
        .sysclk       (sysclk),
        .reset        (reset),
        .cmd_req      (cmd_req),
        .cmd_write    (cmd_write),
        .cmd_addr     (cmd_addr),
        .cmd_wdata    (cmd_wdata),
        .cmd_ack      (cmd_ack),
        .cmd_rdata    (cmd_rdata),
        .board_id     (board_id),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .reg_wen      (reg_wen),
        .chan_rdata   (chan_rdata),
        .bw_start     (bw_start),
        .bw_data      (bw_data),
        .bw_active    (bw_active),
        .bw_addr      (bw_addr),
        .bw_wdata     (bw_wdata),
        .bw_wen       (bw_wen),
        .sample_start (sample_start),
        .sample_raddr (sample_raddr),
        .sample_busy  (sample_busy),
        .sample_rdata (sample_rdata),
        .timestamp    (timestamp)
    );

    // Real-time block write
    block_writer u_block_writer (
        .sysclk    (sysclk),
        .reset     (reset),
        .bw_start  (bw_start),
        .bw_data   (bw_data),
        .bw_active (bw_active),
        .bw_addr   (bw_addr),
        .bw_wdata  (bw_wdata),
        .bw_wen    (bw_wen)
    );

    // Board-side registers
    channel_regs u_channel_regs (
        .sysclk      (sysclk),
        .reset       (reset),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .reg_wen     (reg_wen),
        .chan_rdata  (chan_rdata),
        .adc_value_0 (adc_value_0),
        .adc_value_1 (adc_value_1),
        .adc_value_2 (adc_value_2),
        .adc_value_3 (adc_value_3),
        .setpt_all   (setpt_all),
        .adc_all     (adc_all)
    );

    data_sampler u_data_sampler (
        .sysclk       (sysclk),
        .reset        (reset),
        .sample_start (sample_start),
        .sample_busy  (sample_busy),
        .sample_raddr (sample_raddr),
        .sample_rdata (sample_rdata),
        .setpt_all    (setpt_all),
        .adc_all      (adc_all),
        .timestamp    (timestamp)
    );

endmodule

`default_nettype wire
